/* Makefile */
# Verilator build for the vector coprocessor testbench

VERILATOR ?= verilator
TOP       ?= tb_vecCoproc
FILELIST  ?= sim.f
BUILD_DIR ?= obj_dir
VFLAGS    ?= --binary --timing --assert -j 0
PASS_MSG  ?= SIMULATION PASSED

.PHONY: all compile run clean

all: run

compile:
	$(VERILATOR) $(VFLAGS) --top-module $(TOP) --Mdir $(BUILD_DIR) -f $(FILELIST)

# Pass or fail comes from the printed result, not the exit code
run: compile
	@out="$$(./$(BUILD_DIR)/V$(TOP) 2>&1)"; echo "$$out"; \
	echo "$$out" | grep -q "$(PASS_MSG)"

clean:
	rm -rf $(BUILD_DIR)

/* include/vec_macros.svh */
// Vector coprocessor geometry and host address map
// Register file sizes and AXI4-Lite register locations

`ifndef VEC_MACROS_SVH
`define VEC_MACROS_SVH

// Register file geometry
`define VEC_NR_REGS        8
`define VEC_ELEM_WIDTH     32
`define VEC_REG_WIDTH      128
`define VEC_ELEMS_PER_REG  4
// Upper 3 bits select the register, lower 2 bits the element
`define VEC_VADDR_WIDTH    5

// Host address map, element space is 0x000 to 0x07C
`define VEC_AXI_ADDR_WIDTH 12
`define VEC_CMD_ADDR       12'h100
`define VEC_STATUS_ADDR    12'h104

`endif

/* sim.f */
+incdir+include
source/vecPkg.sv
source/vecRegFile.sv
source/axilCmdFrontend.sv
source/vecLaneAlu.sv
source/vecCoprocTop.sv
testbench/vecCoproc_chk.sv
testbench/tbClockGen.sv
testbench/tb_vecCoproc.sv

/* source/axilCmdFrontend.sv */
// AXI4-Lite command frontend
// Turns host accesses into element writes and reads, vector commands
// and status reads, and holds the B and R response registers

`timescale 1ns/1ps
`include "vec_macros.svh"

module axilCmdFrontend (
  input  logic                              clk,
  input  logic                              rstN_i,
  // Write address and data
  input  logic                              awvalid_i,
  output logic                              awready_o,
  input  logic [`VEC_AXI_ADDR_WIDTH-1:0]    awaddr_i,
  input  logic                              wvalid_i,
  output logic                              wready_o,
  input  logic [`VEC_ELEM_WIDTH-1:0]        wdata_i,
  input  logic [`VEC_ELEM_WIDTH/8-1:0]      wstrb_i,
  // Write response
  output logic                              bvalid_o,
  input  logic                              bready_i,
  output logic [1:0]                        bresp_o,
  // Read address and data
  input  logic                              arvalid_i,
  output logic                              arready_o,
  input  logic [`VEC_AXI_ADDR_WIDTH-1:0]    araddr_i,
  output logic                              rvalid_o,
  input  logic                              rready_i,
  output logic [`VEC_ELEM_WIDTH-1:0]        rdata_o,
  output logic [1:0]                        rresp_o,
  // Register file
  output vecPkg::rfWriteReqT                rfWrReq_o,
  output logic [`VEC_VADDR_WIDTH-1:0]       rfRdAddr_o,
  input  logic [`VEC_ELEM_WIDTH-1:0]        rfRdData_i,
  // Lane ALU
  output vecPkg::aluCmdT                    aluCmd_o,
  output logic                              aluStart_o,
  input  logic                              aluBusy_i
);
  import vecPkg::*;

  localparam logic [1:0] RESP_OKAY   = 2'b00;
  localparam logic [1:0] RESP_SLVERR = 2'b10;
  // First address bit above the element space
  localparam int ELEM_SPACE_TOP = `VEC_VADDR_WIDTH + 2;

  logic wrAccept;
  logic wrIsElem;
  logic wrIsCmd;
  logic opLegal;
  logic rdAccept;
  logic rdIsElem;
  logic rdIsStatus;

  ////////////////////////////////////////////////////////////////////////////
  // Write channel
  // AW and W only transfer together, never while a response or command is pending
  assign awready_o = awvalid_i && wvalid_i && !bvalid_o && !aluBusy_i;
  assign wready_o  = awready_o;
  assign wrAccept  = awready_o;

  assign wrIsElem = (awaddr_i[`VEC_AXI_ADDR_WIDTH-1:ELEM_SPACE_TOP] == '0);
  assign wrIsCmd  = (awaddr_i == `VEC_CMD_ADDR);
  assign opLegal  = wdata_i[3:0] inside {OP_ADD, OP_SUB, OP_AND, OP_OR, OP_XOR};

  // Element write lands at the acceptance edge
  assign rfWrReq_o.valid = wrAccept && wrIsElem;
  assign rfWrReq_o.addr  = awaddr_i[ELEM_SPACE_TOP-1:2];
  assign rfWrReq_o.data  = wdata_i;
  assign rfWrReq_o.be    = wstrb_i;

  // Command fields straight from the write data
  assign aluCmd_o.op  = aluOpE'(wdata_i[3:0]);
  assign aluCmd_o.vd  = wdata_i[6:4];
  assign aluCmd_o.vs1 = wdata_i[10:8];
  assign aluCmd_o.vs2 = wdata_i[14:12];
  assign aluStart_o   = wrAccept && wrIsCmd && opLegal;

  always_ff @(posedge clk or negedge rstN_i) begin
    if (!rstN_i) begin
      bvalid_o <= 1'b0;
    end else if (wrAccept) begin
      bvalid_o <= 1'b1;
    end else if (bready_i) begin
      bvalid_o <= 1'b0;
    end
  end

  always_ff @(posedge clk) begin
    if (wrAccept) begin
      bresp_o <= (wrIsElem || (wrIsCmd && opLegal)) ? RESP_OKAY : RESP_SLVERR;
    end
  end

  ////////////////////////////////////////////////////////////////////////////
  // Read channel
  assign arready_o  = !rvalid_o;
  assign rdAccept   = arvalid_i && arready_o;
  assign rdIsElem   = (araddr_i[`VEC_AXI_ADDR_WIDTH-1:ELEM_SPACE_TOP] == '0);
  assign rdIsStatus = (araddr_i == `VEC_STATUS_ADDR);
  assign rfRdAddr_o = araddr_i[ELEM_SPACE_TOP-1:2];

  always_ff @(posedge clk or negedge rstN_i) begin
    if (!rstN_i) begin
      rvalid_o <= 1'b0;
    end else if (rdAccept) begin
      rvalid_o <= 1'b1;
    end else if (rready_i) begin
      rvalid_o <= 1'b0;
    end
  end

  // Status word carries busy in bit 0
  always_ff @(posedge clk) begin
    if (rdAccept) begin
      if (rdIsElem) begin
        rdata_o <= rfRdData_i;
        rresp_o <= RESP_OKAY;
      end else if (rdIsStatus) begin
        rdata_o <= {{(`VEC_ELEM_WIDTH-1){1'b0}}, aluBusy_i};
        rresp_o <= RESP_OKAY;
      end else begin
        rdata_o <= '0;
        rresp_o <= RESP_SLVERR;
      end
    end
  end

endmodule

/* source/vecCoprocTop.sv */
// Vector coprocessor top level
// Connects the AXI4-Lite frontend, register file and lane ALU

`timescale 1ns/1ps
`include "vec_macros.svh"

module vecCoprocTop (
  input  logic                              clk,
  input  logic                              rstN_i,
  input  logic                              awvalid_i,
  output logic                              awready_o,
  input  logic [`VEC_AXI_ADDR_WIDTH-1:0]    awaddr_i,
  input  logic                              wvalid_i,
  output logic                              wready_o,
  input  logic [`VEC_ELEM_WIDTH-1:0]        wdata_i,
  input  logic [`VEC_ELEM_WIDTH/8-1:0]      wstrb_i,
  output logic                              bvalid_o,
  input  logic                              bready_i,
  output logic [1:0]                        bresp_o,
  input  logic                              arvalid_i,
  output logic                              arready_o,
  input  logic [`VEC_AXI_ADDR_WIDTH-1:0]    araddr_i,
  output logic                              rvalid_o,
  input  logic                              rready_i,
  output logic [`VEC_ELEM_WIDTH-1:0]        rdata_o,
  output logic [1:0]                        rresp_o
);
  import vecPkg::*;

  // Write port 0 from the host, port 1 from the ALU
  rfWriteReqT [1:0]                  rfWrReq;
  // Read ports 0 and 1 for the ALU, port 2 for the host
  logic [2:0][`VEC_VADDR_WIDTH-1:0]  rfRdAddr;
  logic [2:0][`VEC_ELEM_WIDTH-1:0]   rfRdData;
  aluCmdT                            aluCmd;
  logic                              aluStart;
  logic                              aluBusy;

  axilCmdFrontend i_frontend (
    .clk        (clk),
    .rstN_i     (rstN_i),
    .awvalid_i  (awvalid_i),
    .awready_o  (awready_o),
    .awaddr_i   (awaddr_i),
    .wvalid_i   (wvalid_i),
    .wready_o   (wready_o),
    .wdata_i    (wdata_i),
    .wstrb_i    (wstrb_i),
    .bvalid_o   (bvalid_o),
    .bready_i   (bready_i),
    .bresp_o    (bresp_o),
    .arvalid_i  (arvalid_i),
    .arready_o  (arready_o),
    .araddr_i   (araddr_i),
    .rvalid_o   (rvalid_o),
    .rready_i   (rready_i),
    .rdata_o    (rdata_o),
    .rresp_o    (rresp_o),
    .rfWrReq_o  (rfWrReq[0]),
    .rfRdAddr_o (rfRdAddr[2]),
    .rfRdData_i (rfRdData[2]),
    .aluCmd_o   (aluCmd),
    .aluStart_o (aluStart),
    .aluBusy_i  (aluBusy)
  );

  vecRegFile i_regFile (
    .clk      (clk),
    .rstN_i   (rstN_i),
    .wrReq_i  (rfWrReq),
    .rdAddr_i (rfRdAddr),
    .rdData_o (rfRdData)
  );

  vecLaneAlu i_laneAlu (
    .clk       (clk),
    .rstN_i    (rstN_i),
    .cmd_i     (aluCmd),
    .start_i   (aluStart),
    .busy_o    (aluBusy),
    .rdAddrA_o (rfRdAddr[0]),
    .rdAddrB_o (rfRdAddr[1]),
    .rdDataA_i (rfRdData[0]),
    .rdDataB_i (rfRdData[1]),
    .wrReq_o   (rfWrReq[1])
  );

endmodule

/* source/vecLaneAlu.sv */
// Single-lane vector ALU
// Latches a command and processes one element per cycle, lowest first

`timescale 1ns/1ps
`include "vec_macros.svh"

module vecLaneAlu (
  input  logic                          clk,
  input  logic                          rstN_i,
  input  vecPkg::aluCmdT                cmd_i,
  input  logic                          start_i,
  output logic                          busy_o,
  output logic [`VEC_VADDR_WIDTH-1:0]   rdAddrA_o,
  output logic [`VEC_VADDR_WIDTH-1:0]   rdAddrB_o,
  input  logic [`VEC_ELEM_WIDTH-1:0]    rdDataA_i,
  input  logic [`VEC_ELEM_WIDTH-1:0]    rdDataB_i,
  output vecPkg::rfWriteReqT            wrReq_o
);
  import vecPkg::*;

  localparam int ELEM_IDX_W = $clog2(`VEC_ELEMS_PER_REG);

  aluStateE               stateQ;
  aluStateE               stateD;
  logic [ELEM_IDX_W-1:0]  elemQ;
  aluCmdT                 cmdQ;
  logic [`VEC_ELEM_WIDTH-1:0] result;
  logic                   lastElem;

  assign lastElem = (elemQ == ELEM_IDX_W'(`VEC_ELEMS_PER_REG - 1));
  assign busy_o   = (stateQ == RUN);

  ////////////////////////////////////////////////////////////////////////////
  // Sequencer
  always_comb begin
    stateD = stateQ;
    case (stateQ)
      IDLE: if (start_i) stateD = RUN;
      RUN:  if (lastElem) stateD = IDLE;
      default: stateD = IDLE;
    endcase
  end

  always_ff @(posedge clk or negedge rstN_i) begin
    if (!rstN_i) begin
      stateQ <= IDLE;
      elemQ  <= '0;
    end else begin
      stateQ <= stateD;
      // Counter wraps back to 0 after the last element
      if (stateQ == RUN) begin
        elemQ <= elemQ + 1'b1;
      end
    end
  end

  // Command held for the whole run
  always_ff @(posedge clk) begin
    if (start_i && stateQ == IDLE) begin
      cmdQ <= cmd_i;
    end
  end

  ////////////////////////////////////////////////////////////////////////////
  // Datapath
  assign rdAddrA_o = {cmdQ.vs1, elemQ};
  assign rdAddrB_o = {cmdQ.vs2, elemQ};

  always_comb begin
    case (cmdQ.op)
      OP_ADD:  result = rdDataA_i + rdDataB_i;
      OP_SUB:  result = rdDataA_i - rdDataB_i;
      OP_AND:  result = rdDataA_i & rdDataB_i;
      OP_OR:   result = rdDataA_i | rdDataB_i;
      OP_XOR:  result = rdDataA_i ^ rdDataB_i;
      default: result = '0;
    endcase
  end

  // Full-element result write at the end of the cycle
  assign wrReq_o.valid = (stateQ == RUN);
  assign wrReq_o.addr  = {cmdQ.vd, elemQ};
  assign wrReq_o.data  = result;
  assign wrReq_o.be    = '1;

endmodule

/* source/vecPkg.sv */
// Vector coprocessor types
// Opcodes, ALU states and the packed structs passed between blocks

`include "vec_macros.svh"

package vecPkg;

  // Element-wise operations, other codes are illegal
  typedef enum logic [3:0] {
    OP_ADD = 4'd1,
    OP_SUB = 4'd2,
    OP_AND = 4'd3,
    OP_OR  = 4'd4,
    OP_XOR = 4'd5
  } aluOpE;

  // Lane ALU sequencer
  typedef enum logic {
    IDLE,
    RUN
  } aluStateE;

  // One element write into the register file
  typedef struct packed {
    logic                            valid;
    logic [`VEC_VADDR_WIDTH-1:0]     addr;
    logic [`VEC_ELEM_WIDTH-1:0]      data;
    logic [`VEC_ELEM_WIDTH/8-1:0]    be;
  } rfWriteReqT;

  // One whole-register vector command
  typedef struct packed {
    aluOpE      op;
    logic [2:0] vd;
    logic [2:0] vs1;
    logic [2:0] vs2;
  } aluCmdT;

endpackage

/* source/vecRegFile.sv */
// Vector register file
// Element-addressed flop storage with two byte-enabled write ports
// and three combinational read ports, write port 1 has priority

`timescale 1ns/1ps
`include "vec_macros.svh"

module vecRegFile (
  input  logic                                   clk,
  input  logic                                   rstN_i,
  input  vecPkg::rfWriteReqT [1:0]               wrReq_i,
  input  logic [2:0][`VEC_VADDR_WIDTH-1:0]       rdAddr_i,
  output logic [2:0][`VEC_ELEM_WIDTH-1:0]        rdData_o
);

  localparam int NR_BYTES   = `VEC_ELEM_WIDTH / 8;
  localparam int ELEM_IDX_W = $clog2(`VEC_ELEMS_PER_REG);

  // Storage as register, element, byte
  logic [`VEC_NR_REGS-1:0][`VEC_ELEMS_PER_REG-1:0][NR_BYTES-1:0][7:0] mem;

  // Per-port byte enables after address decode
  logic [1:0][`VEC_NR_REGS-1:0][`VEC_ELEMS_PER_REG-1:0][NR_BYTES-1:0] byteWe;

  ////////////////////////////////////////////////////////////////////////////
  // Write decode
  always_comb begin
    for (int p = 0; p < 2; p++) begin
      for (int r = 0; r < `VEC_NR_REGS; r++) begin
        for (int e = 0; e < `VEC_ELEMS_PER_REG; e++) begin
          for (int b = 0; b < NR_BYTES; b++) begin
            byteWe[p][r][e][b] = wrReq_i[p].valid && wrReq_i[p].be[b] &&
                                 (int'(wrReq_i[p].addr) == r * `VEC_ELEMS_PER_REG + e);
          end
        end
      end
    end
  end

  // Byte storage, ALU port first
  always_ff @(posedge clk or negedge rstN_i) begin
    if (!rstN_i) begin
      mem <= '0;
    end else begin
      for (int r = 0; r < `VEC_NR_REGS; r++) begin
        for (int e = 0; e < `VEC_ELEMS_PER_REG; e++) begin
          for (int b = 0; b < NR_BYTES; b++) begin
            if (byteWe[1][r][e][b]) begin
              mem[r][e][b] <= wrReq_i[1].data[b*8 +: 8];
            end else if (byteWe[0][r][e][b]) begin
              mem[r][e][b] <= wrReq_i[0].data[b*8 +: 8];
            end
          end
        end
      end
    end
  end

  ////////////////////////////////////////////////////////////////////////////
  // Read ports
  always_comb begin
    for (int i = 0; i < 3; i++) begin
      rdData_o[i] = mem[rdAddr_i[i][`VEC_VADDR_WIDTH-1:ELEM_IDX_W]]
                       [rdAddr_i[i][ELEM_IDX_W-1:0]];
    end
  end

endmodule

/* testbench/tbClockGen.sv */
// Testbench clock and reset
// 100 ns clock, reset held low for the first 16 cycles

`timescale 1ns/1ps

module tbClockGen (
  output logic clk,
  output logic rstN_o
);

  localparam int HALF_PERIOD  = 50;
  localparam int RESET_CYCLES = 16;

  initial begin
    clk = 1'b0;
    forever #(HALF_PERIOD) clk = ~clk;
  end

  // Release on a falling edge, away from the sampling edge
  initial begin
    rstN_o = 1'b0;
    repeat (RESET_CYCLES) @(posedge clk);
    @(negedge clk);
    rstN_o = 1'b1;
  end

endmodule

/* testbench/tb_vecCoproc.sv */
// Testbench for the vector coprocessor
// AXI4-Lite host model with a shadow register file as reference

`timescale 1ns/1ps
`include "vec_macros.svh"

module tb_vecCoproc;
  import vecPkg::*;

  localparam int MAX_CYCLES = 4000;
  localparam logic [1:0] OKAY   = 2'b00;
  localparam logic [1:0] SLVERR = 2'b10;
  localparam logic [`VEC_AXI_ADDR_WIDTH-1:0] BAD_ADDR = 12'h200;

  logic clk;
  logic rstN;
  logic awvalid;
  logic awready;
  logic [`VEC_AXI_ADDR_WIDTH-1:0] awaddr;
  logic wvalid;
  logic wready;
  logic [31:0] wdata;
  logic [3:0] wstrb;
  logic bvalid;
  logic bready;
  logic [1:0] bresp;
  logic arvalid;
  logic arready;
  logic [`VEC_AXI_ADDR_WIDTH-1:0] araddr;
  logic rvalid;
  logic rready;
  logic [31:0] rdata;
  logic [1:0] rresp;

  integer seed = 32'h8b30_78b0;
  int cycles = 0;
  int respDelayMax = 3;
  int lastWait;
  int writesIssued = 0;
  int readsIssued = 0;
  int awSeen = 0;
  int arSeen = 0;
  int bSeen = 0;
  int rSeen = 0;
  logic [31:0] shadow [8][4];
  // Expected read responses in issue order
  logic [31:0] expData [$];
  logic [1:0]  expResp [$];
  bit          expCheck [$];
  string       expName [$];

  tbClockGen i_clockGen (
    .clk    (clk),
    .rstN_o (rstN)
  );

  vecCoprocTop i_vecCoprocTop (
    .clk (clk), .rstN_i (rstN),
    .awvalid_i (awvalid), .awready_o (awready), .awaddr_i (awaddr),
    .wvalid_i (wvalid), .wready_o (wready), .wdata_i (wdata), .wstrb_i (wstrb),
    .bvalid_o (bvalid), .bready_i (bready), .bresp_o (bresp),
    .arvalid_i (arvalid), .arready_o (arready), .araddr_i (araddr),
    .rvalid_o (rvalid), .rready_i (rready), .rdata_o (rdata), .rresp_o (rresp)
  );

  ////////////////////////////////////////////////////////////////////////////
  // Reference model
  function automatic logic [31:0] refOp(input logic [3:0] op, input logic [31:0] a,
                                        input logic [31:0] b);
    case (op)
      OP_ADD:  return a + b;
      OP_SUB:  return a - b;
      OP_AND:  return a & b;
      OP_OR:   return a | b;
      OP_XOR:  return a ^ b;
      default: return 32'd0;
    endcase
  endfunction

  function automatic logic [31:0] mergeBytes(input logic [31:0] old, input logic [31:0] data,
                                             input logic [3:0] strb);
    logic [31:0] res;
    res = old;
    for (int b = 0; b < 4; b++) begin
      if (strb[b]) begin
        res[b*8 +: 8] = data[b*8 +: 8];
      end
    end
    return res;
  endfunction

  // Element by element, each reads its own sources before its write
  task automatic applyCmd(input logic [3:0] op, input int vd, input int vs1, input int vs2);
    for (int e = 0; e < 4; e++) begin
      shadow[vd][e] = refOp(op, shadow[vs1][e], shadow[vs2][e]);
    end
  endtask

  function automatic logic [`VEC_AXI_ADDR_WIDTH-1:0] elemAddr(input int r, input int e);
    return 12'((r * 4 + e) * 4);
  endfunction

  function automatic logic [31:0] cmdWord(input logic [3:0] op, input logic [2:0] vd,
                                          input logic [2:0] vs1, input logic [2:0] vs2);
    return {17'd0, vs2, 1'b0, vs1, 1'b0, vd, op};
  endfunction

  function automatic int respDelay();
    return int'($unsigned($random(seed)) % (respDelayMax + 1));
  endfunction

  ////////////////////////////////////////////////////////////////////////////
  // Checks
  task automatic abortRun(input string why);
    $display("%s", why);
    $display("SIMULATION FAILED");
    $fatal(1, "run stopped on error");
  endtask

  task automatic compare(input string name, input logic [31:0] expV, input logic [31:0] actV);
    if (actV !== expV) begin
      abortRun($sformatf("mismatch %s expected 0x%08h actual 0x%08h", name, expV, actV));
    end
  endtask

  ////////////////////////////////////////////////////////////////////////////
  // AXI4-Lite host tasks
  task automatic writeWord(input logic [11:0] addr, input logic [31:0] data,
                           input logic [3:0] strb, input logic [1:0] expR, input string name);
    logic [1:0] resp;
    @(negedge clk);
    awvalid = 1'b1;
    wvalid  = 1'b1;
    awaddr  = addr;
    wdata   = data;
    wstrb   = strb;
    writesIssued++;
    lastWait = 0;
    do begin
      @(negedge clk);
      lastWait++;
    end while (!bvalid);
    awvalid = 1'b0;
    wvalid  = 1'b0;
    resp = bresp;
    repeat (respDelay()) @(negedge clk);
    bready = 1'b1;
    @(negedge clk);
    bready = 1'b0;
    if (bvalid) begin
      abortRun($sformatf("write response for %s was given twice", name));
    end
    compare({name, " bresp"}, 32'(expR), 32'(resp));
  endtask

  task automatic readWord(input logic [11:0] addr, input logic [31:0] expD,
                          input logic [1:0] expR, input bit check, input string name,
                          output logic [31:0] data);
    expData.push_back(expD);
    expResp.push_back(expR);
    expCheck.push_back(check);
    expName.push_back(name);
    readsIssued++;
    @(negedge clk);
    arvalid = 1'b1;
    araddr  = addr;
    do begin
      @(negedge clk);
    end while (!rvalid);
    arvalid = 1'b0;
    data = rdata;
    repeat (respDelay()) @(negedge clk);
    rready = 1'b1;
    @(negedge clk);
    rready = 1'b0;
    if (rvalid) begin
      abortRun($sformatf("read response for %s was given twice", name));
    end
  endtask

  task automatic checkElem(input int r, input int e, input string name);
    logic [31:0] d;
    readWord(elemAddr(r, e), shadow[r][e], OKAY, 1'b1,
             $sformatf("%s v%0d[%0d]", name, r, e), d);
  endtask

  task automatic waitIdle();
    logic [31:0] st;
    do begin
      readWord(`VEC_STATUS_ADDR, 32'd0, OKAY, 1'b0, "status poll", st);
    end while (st[0]);
  endtask

  ////////////////////////////////////////////////////////////////////////////
  // Response compare and watchdog
  always @(posedge clk) begin
    if ((awvalid && awready) != (wvalid && wready)) begin
      abortRun("write address and write data were not accepted in the same cycle");
    end
    if (awvalid && awready) begin
      awSeen++;
    end
    if (arvalid && arready) begin
      arSeen++;
    end
    if (rvalid && rready) begin
      rSeen++;
      if (expData.size() == 0) begin
        abortRun("read response arrived with no read outstanding");
      end else begin
        if (expCheck[0]) begin
          compare(expName[0], expData[0], rdata);
        end
        compare({expName[0], " rresp"}, 32'(expResp[0]), 32'(rresp));
        void'(expData.pop_front());
        void'(expResp.pop_front());
        void'(expCheck.pop_front());
        void'(expName.pop_front());
      end
    end
    if (bvalid && bready) begin
      bSeen++;
    end
  end

  always @(posedge clk) begin
    cycles++;
    if (cycles >= MAX_CYCLES) begin
      abortRun($sformatf("timeout, run did not finish within %0d cycles", MAX_CYCLES));
    end
    if (i_vecCoprocTop.i_chk.failCnt != 0) begin
      abortRun("an assertion in the bound checker failed");
    end
  end

  ////////////////////////////////////////////////////////////////////////////
  // Tests
  initial begin
    logic [31:0] d;
    logic [31:0] rnd;
    logic [2:0] vd;
    logic [2:0] vs1;
    logic [2:0] vs2;
    logic [1:0] e;
    logic [3:0] strbList [4];
    awvalid = 1'b0;
    awaddr  = '0;
    wvalid  = 1'b0;
    wdata   = '0;
    wstrb   = '0;
    bready  = 1'b0;
    arvalid = 1'b0;
    araddr  = '0;
    rready  = 1'b0;
    strbList = '{4'b0001, 4'b0110, 4'b1000, 4'b1010};
    for (int r = 0; r < 8; r++) begin
      for (int k = 0; k < 4; k++) begin
        shadow[r][k] = 32'd0;
      end
    end
    @(posedge rstN);

    // Reset state
    readWord(`VEC_STATUS_ADDR, 32'd0, OKAY, 1'b1, "reset status", d);
    for (int r = 0; r < 8; r++) begin
      for (int k = 0; k < 4; k++) begin
        checkElem(r, k, "reset");
      end
    end

    // Full-word writes, then read-back
    for (int r = 0; r < 8; r++) begin
      for (int k = 0; k < 4; k++) begin
        rnd = $random(seed);
        writeWord(elemAddr(r, k), rnd, 4'hF, OKAY, "element write");
        shadow[r][k] = rnd;
      end
    end
    for (int r = 0; r < 8; r++) begin
      for (int k = 0; k < 4; k++) begin
        checkElem(r, k, "read-back");
      end
    end

    // Partial byte strobes
    for (int i = 0; i < 4; i++) begin
      vd  = 3'($random(seed));
      e   = 2'($random(seed));
      rnd = $random(seed);
      writeWord(elemAddr(vd, e), rnd, strbList[i], OKAY, "strobe write");
      shadow[vd][e] = mergeBytes(shadow[vd][e], rnd, strbList[i]);
      checkElem(vd, e, $sformatf("strobe %b", strbList[i]));
    end

    // One command per legal opcode, two of them overwrite a source
    for (int k = 1; k <= 5; k++) begin
      vd  = 3'($random(seed));
      vs1 = 3'($random(seed));
      vs2 = 3'($random(seed));
      if (k == 2) begin
        vd = vs1;
      end
      if (k == 5) begin
        vd = vs2;
      end
      writeWord(`VEC_CMD_ADDR, cmdWord(4'(k), vd, vs1, vs2), 4'hF, OKAY, "command");
      applyCmd(4'(k), vd, vs1, vs2);
      waitIdle();
      for (int j = 0; j < 4; j++) begin
        checkElem(vd, j, $sformatf("op %0d", k));
      end
    end

    // Error responses leave the registers alone
    // Status read falls inside the 4 cycles a wrongly started command would run
    respDelayMax = 0;
    writeWord(`VEC_CMD_ADDR, cmdWord(4'hF, 3'd0, 3'd1, 3'd2), 4'hF, SLVERR, "illegal opcode");
    readWord(`VEC_STATUS_ADDR, 32'd0, OKAY, 1'b1, "status after illegal opcode", d);
    respDelayMax = 3;
    writeWord(BAD_ADDR, 32'hdead_beef, 4'hF, SLVERR, "unmapped write");
    writeWord(`VEC_STATUS_ADDR, 32'h1, 4'hF, SLVERR, "status write");
    readWord(BAD_ADDR, 32'd0, SLVERR, 1'b1, "unmapped read", d);
    for (int j = 0; j < 4; j++) begin
      checkElem(0, j, "after errors");
    end

    // Element write issued while the ALU runs must wait for it
    respDelayMax = 0;
    vd  = 3'($random(seed));
    vs1 = 3'($random(seed));
    vs2 = 3'($random(seed));
    writeWord(`VEC_CMD_ADDR, cmdWord(OP_SUB, vd, vs1, vs2), 4'hF, OKAY, "stall command");
    applyCmd(OP_SUB, vd, vs1, vs2);
    rnd = $random(seed);
    writeWord(elemAddr(vd, 2), rnd, 4'hF, OKAY, "stalled write");
    shadow[vd][2] = rnd;
    compare("stalled write waited", 32'd1, 32'(lastWait > 1));
    respDelayMax = 3;
    waitIdle();
    for (int j = 0; j < 4; j++) begin
      checkElem(vd, j, "after stall");
    end

    @(negedge clk);
    if (awSeen != writesIssued || arSeen != readsIssued) begin
      abortRun($sformatf("requests lost or repeated, %0d of %0d writes, %0d of %0d reads",
                         awSeen, writesIssued, arSeen, readsIssued));
    end else if (bSeen != writesIssued || rSeen != readsIssued || expData.size() != 0) begin
      abortRun($sformatf("responses lost or repeated, %0d of %0d writes, %0d of %0d reads",
                         bSeen, writesIssued, rSeen, readsIssued));
    end else begin
      $display("SIMULATION PASSED");
      $finish;
    end
  end

endmodule

/* testbench/vecCoproc_chk.sv */
// Protocol checker for the vector coprocessor
// Handshake stability and ALU busy rules, bound to the top level

`timescale 1ns/1ps

module vecCoproc_chk (
  input logic clk,
  input logic rstN_i,
  input logic awvalid_i,
  input logic awready_i,
  input logic wvalid_i,
  input logic wready_i,
  input logic bvalid_i,
  input logic bready_i,
  input logic arvalid_i,
  input logic arready_i,
  input logic rvalid_i,
  input logic rready_i,
  input logic busy_i
);

  int failCnt = 0;
  // Consecutive busy cycles seen so far
  int busyRun;

  task automatic noteFail(input string what);
    failCnt++;
    $error("%s", what);
  endtask

  always_ff @(posedge clk or negedge rstN_i) begin
    if (!rstN_i) begin
      busyRun <= 0;
    end else if (busy_i) begin
      busyRun <= busyRun + 1;
    end else begin
      busyRun <= 0;
    end
  end

  property validHold(logic valid, logic ready);
    @(posedge clk) disable iff (!rstN_i) valid && !ready |=> valid;
  endproperty

  ////////////////////////////////////////////////////////////////////////////
  // Handshake stability
  awHold: assert property (validHold(awvalid_i, awready_i))
    else noteFail("AWVALID dropped before its transfer");
  wHold: assert property (validHold(wvalid_i, wready_i))
    else noteFail("WVALID dropped before its transfer");
  arHold: assert property (validHold(arvalid_i, arready_i))
    else noteFail("ARVALID dropped before its transfer");
  bHold: assert property (validHold(bvalid_i, bready_i))
    else noteFail("BVALID dropped before its transfer");
  rHold: assert property (validHold(rvalid_i, rready_i))
    else noteFail("RVALID dropped before its transfer");

  ////////////////////////////////////////////////////////////////////////////
  // ALU busy rules
  busyLength: assert property (@(posedge clk) disable iff (!rstN_i)
    busy_i |-> busyRun < 4)
    else noteFail("busy high for more than 4 cycles");
  noAcceptBusy: assert property (@(posedge clk) disable iff (!rstN_i)
    awready_i |-> !busy_i)
    else noteFail("AWREADY high while the ALU is busy");

endmodule

bind vecCoprocTop vecCoproc_chk i_chk (
  .clk       (clk),
  .rstN_i    (rstN_i),
  .awvalid_i (awvalid_i),
  .awready_i (awready_o),
  .wvalid_i  (wvalid_i),
  .wready_i  (wready_o),
  .bvalid_i  (bvalid_o),
  .bready_i  (bready_i),
  .arvalid_i (arvalid_i),
  .arready_i (arready_o),
  .rvalid_i  (rvalid_o),
  .rready_i  (rready_i),
  .busy_i    (aluBusy)
);
